// ==== source/mcu_bus_pkg.sv ====
// CPU bus definitions; addresses are word addresses (A23..A1) and only UDS carries register data
`default_nettype none

package mcu_bus_pkg;

    // ========================================================================
    // Address word decoded two ways from the same A23..A1
    // ========================================================================

    // Page in A23..A16 and word offset in A15..A1 for a normal bus cycle
    typedef struct packed {
        logic [7:0]  page;
        logic [14:0] offset;
    } reg_addr_t;

    // Only A3..A1 carry the level during an interrupt acknowledge
    typedef struct packed {
        logic [19:0] unused;
        logic [2:0]  level;
    } ack_addr_t;

    typedef union packed {
        reg_addr_t reg_view;
        ack_addr_t ack_view;
    } cpu_addr_u;

    // ========================================================================
    // Register map and function codes
    // ========================================================================

    localparam logic [7:0]  IO_PAGE      = 8'hFF;
    localparam logic [14:0] SYNC_REG_OFS = 15'h4105;    // FF820A
    localparam logic [14:0] MODE_REG_OFS = 15'h4130;    // FF8260

    localparam logic [2:0]  FC_IACK      = 3'b111;      // CPU space cycle

    // Autovector levels seen during acknowledge
    localparam logic [2:0]  LVL_HINT     = 3'd2;
    localparam logic [2:0]  LVL_VINT     = 3'd4;
    localparam logic [2:0]  LVL_MFP      = 3'd6;        // MFP supplies its own vector

endpackage

`default_nettype wire

// ==== source/mcu_video_pkg.sv ====
// Video timing tables in 2 MHz ticks and lines; table entry 3 is a spare copy of MONO
`default_nettype none

package mcu_video_pkg;

    // Encoding follows the register bits with NTSC unless pal or mde1 set
    typedef enum logic [1:0] {
        MODE_NTSC = 2'd0,
        MODE_PAL  = 2'd1,
        MODE_MONO = 2'd2
    } video_mode_e;

    localparam int TICK_DIV = 16;       // clk32 cycles per 2 MHz tick

    localparam int HCNT_W   = 7;
    localparam int VCNT_W   = 9;

    // ========================================================================
    // Per-mode tables indexed by video_mode_e
    // Order is NTSC, PAL, MONO, spare
    // ========================================================================

    localparam int H_TOTAL   [4] = '{127, 128, 56, 56};     // Ticks per line
    localparam int V_TOTAL   [4] = '{263, 313, 501, 501};   // Lines per frame

    // Sync sits at the end of the line and of the frame
    localparam int HSYNC_LEN [4] = '{10, 10, 6, 6};
    localparam int VSYNC_LEN [4] = '{3, 3, 2, 2};

    // Display window
    localparam int HDE_FIRST [4] = '{15, 16, 3, 3};
    localparam int HDE_LEN   [4] = '{80, 80, 40, 40};
    localparam int VDE_FIRST [4] = '{34, 63, 36, 36};
    localparam int VDE_LEN   [4] = '{200, 200, 400, 400};

    // Blanking at the end of line and frame in colour modes only
    localparam int HBLANK_LEN = 14;
    localparam int VBLANK_LEN = 20;

endpackage

`default_nettype wire

// ==== source/cpu_port.sv ====
// Only sync (FF820A) and resolution (FF8260) exist here; LDS is ignored and bits 9:8 ride on UDS
`timescale 1ns/1ps
`default_nettype none

module cpu_port (
    input  wire                             clk32,
    input  wire                             porb,
    input  wire                             as_n_i,
    input  wire                             rw_i,
    input  wire                             uds_n_i,
    input  wire [2:0]                       fc_i,
    input  wire mcu_bus_pkg::cpu_addr_u     addr_i,
    input  wire [15:0]                      din_i,
    output logic [15:0]                     dout_o,
    output logic                            dtack_n_o,
    output logic                            vpa_n_o,
    output logic                            iack_n_o,
    output mcu_video_pkg::video_mode_e      mode_o,
    output logic                            hint_ack_o,
    output logic                            vint_ack_o
);

    import mcu_bus_pkg::*;
    import mcu_video_pkg::*;

    logic iack_cyc;
    logic io_page;
    logic sync_sel;
    logic mode_sel;
    logic reg_wr;
    logic pal_q;
    logic mde1_q;
    logic mde0_q;

    // ========================================================================
    // Address decode
    // ========================================================================

    assign iack_cyc = !as_n_i && (fc_i == FC_IACK);

    // Register view only outside acknowledge cycles
    assign io_page  = !as_n_i && !iack_cyc && (addr_i.reg_view.page == IO_PAGE);
    assign sync_sel = io_page && (addr_i.reg_view.offset == SYNC_REG_OFS);
    assign mode_sel = io_page && (addr_i.reg_view.offset == MODE_REG_OFS);
    assign reg_wr   = !uds_n_i && !rw_i;

    // ========================================================================
    // Mode registers
    // ========================================================================

    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            pal_q  <= 1'b0;
            mde1_q <= 1'b0;
            mde0_q <= 1'b0;
        end else begin
            if (sync_sel && reg_wr) begin
                pal_q <= din_i[9];              // 50 Hz select
            end
            if (mode_sel && reg_wr) begin
                mde1_q <= din_i[9];
                mde0_q <= din_i[8];
            end
        end
    end

    // Undriven bus bits float high
    always_comb begin
        dout_o = '1;
        if (sync_sel) begin
            dout_o[9:8] = {pal_q, 1'b0};
        end else if (mode_sel) begin
            dout_o[9:8] = {mde1_q, mde0_q};
        end
    end

    assign dtack_n_o = !(sync_sel || mode_sel);

    // Acknowledge decode uses the level view of the same address
    assign hint_ack_o = iack_cyc && (addr_i.ack_view.level == LVL_HINT);
    assign vint_ack_o = iack_cyc && (addr_i.ack_view.level == LVL_VINT);
    assign vpa_n_o    = !(hint_ack_o || vint_ack_o);    // Autovectored
    assign iack_n_o   = !(iack_cyc && (addr_i.ack_view.level == LVL_MFP));

    // Mono wins over the sync bit; mde0 only reads back
    always_comb begin
        if (mde1_q) begin
            mode_o = MODE_MONO;
        end else if (pal_q) begin
            mode_o = MODE_PAL;
        end else begin
            mode_o = MODE_NTSC;
        end
    end

endmodule

`default_nettype wire

// ==== source/video_timing.sv ====
// Beam counters run from an internal 2 MHz divider; a mode change waits for the next frame
`timescale 1ns/1ps
`default_nettype none

module video_timing (
    input  wire                                 clk32,
    input  wire                                 porb,
    input  wire mcu_video_pkg::video_mode_e     mode_i,
    output mcu_video_pkg::video_mode_e          active_mode_o,
    output logic [mcu_video_pkg::HCNT_W-1:0]    hcnt_o,
    output logic [mcu_video_pkg::VCNT_W-1:0]    vcnt_o,
    output logic                                hsync_o,
    output logic                                vsync_o,
    output logic                                hsync_start_o,
    output logic                                vsync_start_o
);

    import mcu_video_pkg::*;

    logic [$clog2(TICK_DIV)-1:0] div_q;
    logic tick;
    logic line_end;
    logic frame_end;
    int   h_total;
    int   v_total;
    int   hs_first;
    int   vs_first;

    // ========================================================================
    // 2 MHz tick
    // ========================================================================

    assign tick = (int'(div_q) == TICK_DIV - 1);

    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            div_q <= '0;
        end else if (tick) begin
            div_q <= '0;
        end else begin
            div_q <= div_q + 1'b1;
        end
    end

    // ========================================================================
    // Line and frame counters
    // ========================================================================

    assign h_total   = H_TOTAL[active_mode_o];
    assign v_total   = V_TOTAL[active_mode_o];
    assign line_end  = tick && (int'(hcnt_o) == h_total - 1);
    assign frame_end = line_end && (int'(vcnt_o) == v_total - 1);

    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            hcnt_o        <= '0;
            vcnt_o        <= '0;
            active_mode_o <= MODE_NTSC;
        end else if (tick) begin
            if (line_end) begin
                hcnt_o <= '0;
                if (frame_end) begin
                    vcnt_o        <= '0;
                    active_mode_o <= mode_i;    // Takes effect from line 0
                end else begin
                    vcnt_o <= vcnt_o + 1'b1;
                end
            end else begin
                hcnt_o <= hcnt_o + 1'b1;
            end
        end
    end

    // Sync spans close each line and each frame
    assign hs_first = h_total - HSYNC_LEN[active_mode_o];
    assign vs_first = v_total - VSYNC_LEN[active_mode_o];

    assign hsync_o = (int'(hcnt_o) >= hs_first);
    assign vsync_o = (int'(vcnt_o) >= vs_first);

    // Counters step as div_q wraps, so div_q at zero is the first cycle of a count
    assign hsync_start_o = (int'(hcnt_o) == hs_first) && (div_q == '0);
    assign vsync_start_o = (int'(vcnt_o) == vs_first) && (hcnt_o == '0) && (div_q == '0);

endmodule

`default_nettype wire

// ==== source/video_outputs.sv ====
// Video outputs lag the counters by one clk32; IPL0 is not driven, MFP requests go out as level 6
`timescale 1ns/1ps
`default_nettype none

module video_outputs (
    input  wire                                 clk32,
    input  wire                                 porb,
    input  wire mcu_video_pkg::video_mode_e     mode_i,
    input  wire [mcu_video_pkg::HCNT_W-1:0]     hcnt_i,
    input  wire [mcu_video_pkg::VCNT_W-1:0]     vcnt_i,
    input  wire                                 hsync_i,
    input  wire                                 vsync_i,
    input  wire                                 hsync_start_i,
    input  wire                                 vsync_start_i,
    input  wire                                 hint_ack_i,
    input  wire                                 vint_ack_i,
    input  wire                                 mfpint_n_i,
    output logic                                hsync_n_o,
    output logic                                vsync_n_o,
    output logic                                de_o,
    output logic                                blank_n_o,
    output logic                                ipl1_n_o,
    output logic                                ipl2_n_o
);

    import mcu_video_pkg::*;

    int   h_pos;
    int   v_pos;
    logic hde;
    logic vde;
    logic hblank;
    logic vblank;
    logic hint_q;
    logic vint_q;

    // ========================================================================
    // Display and blanking windows
    // ========================================================================

    assign h_pos = int'(hcnt_i);
    assign v_pos = int'(vcnt_i);

    assign hde = (h_pos >= HDE_FIRST[mode_i]) && (h_pos < HDE_FIRST[mode_i] + HDE_LEN[mode_i]);
    assign vde = (v_pos >= VDE_FIRST[mode_i]) && (v_pos < VDE_FIRST[mode_i] + VDE_LEN[mode_i]);

    // Mono monitor needs no blanking
    assign hblank = (mode_i != MODE_MONO) && (h_pos >= H_TOTAL[mode_i] - HBLANK_LEN);
    assign vblank = (mode_i != MODE_MONO) && (v_pos >= V_TOTAL[mode_i] - VBLANK_LEN);

    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            hsync_n_o <= 1'b1;
            vsync_n_o <= 1'b1;
            de_o      <= 1'b0;
            blank_n_o <= 1'b1;
        end else begin
            hsync_n_o <= !hsync_i;
            vsync_n_o <= !vsync_i;
            de_o      <= hde && vde;
            blank_n_o <= !(hblank || vblank);
        end
    end

    // ========================================================================
    // Interrupt latches where an acknowledge beats a new sync
    // ========================================================================

    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            hint_q <= 1'b0;
            vint_q <= 1'b0;
        end else begin
            if (hint_ack_i) begin
                hint_q <= 1'b0;
            end else if (hsync_start_i) begin
                hint_q <= 1'b1;
            end
            if (vint_ack_i) begin
                vint_q <= 1'b0;
            end else if (vsync_start_i) begin
                vint_q <= 1'b1;
            end
        end
    end

    // Level 4 for VBL, level 2 for HBL, MFP pulls both for level 6
    assign ipl2_n_o = !(vint_q || !mfpint_n_i);
    assign ipl1_n_o = !((hint_q && !vint_q) || !mfpint_n_i);

endmodule

`default_nettype wire

// ==== source/gst_video_mcu.sv ====
// Video timing and mode register slice of the memory controller; no memory or chip selects
`timescale 1ns/1ps
`default_nettype none

module gst_video_mcu (
    input  wire                             clk32,
    input  wire                             porb,
    input  wire                             as_n_i,
    input  wire                             rw_i,
    input  wire                             uds_n_i,
    input  wire [2:0]                       fc_i,
    input  wire mcu_bus_pkg::cpu_addr_u     addr_i,
    input  wire [15:0]                      din_i,
    output logic [15:0]                     dout_o,
    output logic                            dtack_n_o,
    output logic                            vpa_n_o,
    output logic                            iack_n_o,
    input  wire                             mfpint_n_i,
    output logic                            hsync_n_o,
    output logic                            vsync_n_o,
    output logic                            de_o,
    output logic                            blank_n_o,
    output logic                            ipl1_n_o,
    output logic                            ipl2_n_o
);

    import mcu_video_pkg::*;

    video_mode_e         sel_mode;      // From the registers
    video_mode_e         frame_mode;    // Latched at frame start
    logic                hint_ack;
    logic                vint_ack;
    logic [HCNT_W-1:0]   hcnt;
    logic [VCNT_W-1:0]   vcnt;
    logic                hsync;
    logic                vsync;
    logic                hsync_start;
    logic                vsync_start;

    cpu_port u_cpu_port (
        .clk32      (clk32),
        .porb       (porb),
        .as_n_i     (as_n_i),
        .rw_i       (rw_i),
        .uds_n_i    (uds_n_i),
        .fc_i       (fc_i),
        .addr_i     (addr_i),
        .din_i      (din_i),
        .dout_o     (dout_o),
        .dtack_n_o  (dtack_n_o),
        .vpa_n_o    (vpa_n_o),
        .iack_n_o   (iack_n_o),
        .mode_o     (sel_mode),
        .hint_ack_o (hint_ack),
        .vint_ack_o (vint_ack)
    );

    video_timing u_video_timing (
        .clk32         (clk32),
        .porb          (porb),
        .mode_i        (sel_mode),
        .active_mode_o (frame_mode),
        .hcnt_o        (hcnt),
        .vcnt_o        (vcnt),
        .hsync_o       (hsync),
        .vsync_o       (vsync),
        .hsync_start_o (hsync_start),
        .vsync_start_o (vsync_start)
    );

    video_outputs u_video_outputs (
        .clk32         (clk32),
        .porb          (porb),
        .mode_i        (frame_mode),
        .hcnt_i        (hcnt),
        .vcnt_i        (vcnt),
        .hsync_i       (hsync),
        .vsync_i       (vsync),
        .hsync_start_i (hsync_start),
        .vsync_start_i (vsync_start),
        .hint_ack_i    (hint_ack),
        .vint_ack_i    (vint_ack),
        .mfpint_n_i    (mfpint_n_i),
        .hsync_n_o     (hsync_n_o),
        .vsync_n_o     (vsync_n_o),
        .de_o          (de_o),
        .blank_n_o     (blank_n_o),
        .ipl1_n_o      (ipl1_n_o),
        .ipl2_n_o      (ipl2_n_o)
    );

endmodule

`default_nettype wire

// ==== dv/tb_gst_video_mcu.sv ====
// Runs NTSC, PAL then MONO for about three frames each; the first error stops the run
`timescale 1ns/1ps
`default_nettype none

module tb_gst_video_mcu;

    import mcu_bus_pkg::*;
    import mcu_video_pkg::*;

    // Three frames of every mode plus margin in clk32 cycles
    localparam longint FRAME_SUM = longint'(TICK_DIV) * (H_TOTAL[0] * V_TOTAL[0]
                                   + H_TOTAL[1] * V_TOTAL[1] + H_TOTAL[2] * V_TOTAL[2]);
    localparam longint WD_CYCLES = 3 * FRAME_SUM + 200000;

    logic        clk32 = 1'b0;
    logic        porb;
    logic        as_n, rw, uds_n, mfpint_n;
    logic [2:0]  fc;
    cpu_addr_u   addr;
    logic [15:0] din;
    wire  [15:0] dout_o;
    wire         dtack_n_o, vpa_n_o, iack_n_o, hsync_n_o, vsync_n_o;
    wire         de_o, blank_n_o, ipl1_n_o, ipl2_n_o;

    // One-cycle check strobes
    logic        reg_acc = 1'b0, oth_acc = 1'b0, rd_chk = 1'b0;
    logic        vpa_exp = 1'b0, iack_exp = 1'b0, ipl_chk = 1'b0;
    logic [15:0] exp_dout = '1;
    logic [1:0]  ipl_exp = 2'b11;   // {ipl2, ipl1}

    // Expected video timing of the mode under test
    logic meas = 1'b0;
    logic exp_mono = 1'b0;
    int   exp_hper, exp_hlow, exp_vper, exp_vlow, exp_deline, exp_delines;
    int   exp_blank;

    // Edge monitor state
    int   cyc = 0, hs_fall = 0, vs_fall = 0, hs_per = 0, hs_low = 0, vs_per = 0, vs_low = 0;
    int   de_run = 0, de_line = 0, de_lines = 0, de_frame = 0;
    int   bl_run = 0, bl_frame = 0;
    logic hs_q = 1'b1, vs_q = 1'b1;
    logic hs_chk = 1'b0, hl_chk = 1'b0, vs_chk = 1'b0, vl_chk = 1'b0;

    gst_video_mcu UUT (
        .clk32(clk32), .porb(porb), .as_n_i(as_n), .rw_i(rw), .uds_n_i(uds_n),
        .fc_i(fc), .addr_i(addr), .din_i(din), .dout_o(dout_o), .dtack_n_o(dtack_n_o),
        .vpa_n_o(vpa_n_o), .iack_n_o(iack_n_o), .mfpint_n_i(mfpint_n),
        .hsync_n_o(hsync_n_o), .vsync_n_o(vsync_n_o), .de_o(de_o), .blank_n_o(blank_n_o),
        .ipl1_n_o(ipl1_n_o), .ipl2_n_o(ipl2_n_o)
    );

    always #50 clk32 = ~clk32;

    task automatic stop_on_error(string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        $display("Regression failed");
        $fatal(1, "check failed");
    endtask

    // ========================================================================
    // Measurements from the sync and display edges
    // ========================================================================

    always @(posedge clk32) begin
        cyc    <= cyc + 1;
        hs_q   <= hsync_n_o;
        vs_q   <= vsync_n_o;
        hs_chk <= 1'b0;
        hl_chk <= 1'b0;
        vs_chk <= 1'b0;
        vl_chk <= 1'b0;
        if (de_o) begin
            de_run <= de_run + 1;
        end
        if (!blank_n_o) begin
            bl_run <= bl_run + 1;
        end
        if (hs_q && !hsync_n_o) begin      // Line start
            hs_per  <= cyc - hs_fall;
            hs_fall <= cyc;
            hs_chk  <= meas;
            de_line <= de_run;
            de_run  <= 0;
            if (de_run != 0) begin
                de_lines <= de_lines + 1;
            end
        end
        if (!hs_q && hsync_n_o) begin
            hs_low <= cyc - hs_fall;
            hl_chk <= meas;
        end
        if (vs_q && !vsync_n_o) begin      // Frame start
            vs_per   <= cyc - vs_fall;
            vs_fall  <= cyc;
            vs_chk   <= meas;
            de_frame <= de_lines;
            de_lines <= 0;
            bl_frame <= bl_run;
            bl_run   <= int'(!blank_n_o);   // This cycle opens the next frame
        end
        if (!vs_q && vsync_n_o) begin
            vs_low <= cyc - vs_fall;
            vl_chk <= meas;
        end
    end

    // ========================================================================
    // Assertions
    // ========================================================================

    a_reg_dtack: assert property (@(posedge clk32) disable iff (!porb) reg_acc |-> !dtack_n_o)
        else stop_on_error("dtack_n_o high on register access");
    a_readback: assert property (@(posedge clk32) disable iff (!porb) rd_chk |-> dout_o == exp_dout)
        else stop_on_error($sformatf("dout_o %h, expected %h", dout_o, exp_dout));
    a_other: assert property (@(posedge clk32) disable iff (!porb)
            oth_acc |-> dtack_n_o && dout_o == 16'hFFFF)
        else stop_on_error("unmapped address answered");
    a_vpa: assert property (@(posedge clk32) disable iff (!porb) vpa_exp |-> !vpa_n_o)
        else stop_on_error("vpa_n_o high in autovector acknowledge");
    a_iack: assert property (@(posedge clk32) disable iff (!porb) iack_exp |-> !iack_n_o)
        else stop_on_error("iack_n_o high in level 6 acknowledge");
    a_ipl: assert property (@(posedge clk32) disable iff (!porb)
            ipl_chk |-> {ipl2_n_o, ipl1_n_o} == ipl_exp)
        else stop_on_error($sformatf("ipl2/ipl1 %b%b, expected %b", ipl2_n_o, ipl1_n_o, ipl_exp));
    a_hper: assert property (@(posedge clk32) hs_chk |-> hs_per == exp_hper)
        else stop_on_error($sformatf("hsync period %0d, expected %0d", hs_per, exp_hper));
    a_hlow: assert property (@(posedge clk32) hl_chk |-> hs_low == exp_hlow)
        else stop_on_error($sformatf("hsync width %0d, expected %0d", hs_low, exp_hlow));
    a_vper: assert property (@(posedge clk32) vs_chk |-> vs_per == exp_vper)
        else stop_on_error($sformatf("vsync period %0d, expected %0d", vs_per, exp_vper));
    a_vlow: assert property (@(posedge clk32) vl_chk |-> vs_low == exp_vlow)
        else stop_on_error($sformatf("vsync width %0d, expected %0d", vs_low, exp_vlow));
    a_deline: assert property (@(posedge clk32) hs_chk |-> de_line == 0 || de_line == exp_deline)
        else stop_on_error($sformatf("de cycles in line %0d", de_line));
    a_deframe: assert property (@(posedge clk32) vs_chk |-> de_frame == exp_delines)
        else stop_on_error($sformatf("display lines %0d, expected %0d", de_frame, exp_delines));
    a_blank: assert property (@(posedge clk32) vs_chk |-> bl_frame == exp_blank)
        else stop_on_error($sformatf("blank cycles in frame %0d, expected %0d",
                                     bl_frame, exp_blank));
    a_mono_blank: assert property (@(posedge clk32) meas && exp_mono |-> blank_n_o)
        else stop_on_error("blank_n_o low in MONO");

    // ========================================================================
    // Bus cycles
    // ========================================================================

    task automatic bus_cycle(logic [22:0] a, logic [15:0] d, logic wr, logic is_reg,
                             logic [15:0] exp);
        @(posedge clk32);
        as_n     <= 1'b0;
        uds_n    <= 1'b0;
        rw       <= !wr;
        fc       <= 3'b101;     // Supervisor data
        addr     <= a;
        din      <= d;
        reg_acc  <= is_reg;
        oth_acc  <= !is_reg;
        rd_chk   <= is_reg && !wr;
        exp_dout <= exp;
        @(posedge clk32);
        as_n    <= 1'b1;
        uds_n   <= 1'b1;
        rw      <= 1'b1;
        reg_acc <= 1'b0;
        oth_acc <= 1'b0;
        rd_chk  <= 1'b0;
        repeat ($urandom % 4) @(posedge clk32);
    endtask

    task automatic ack_cycle(logic [2:0] lvl);
        @(posedge clk32);
        as_n     <= 1'b0;
        fc       <= FC_IACK;
        addr     <= {20'h0, lvl};
        vpa_exp  <= (lvl == LVL_HINT) || (lvl == LVL_VINT);
        iack_exp <= (lvl == LVL_MFP);
        @(posedge clk32);
        as_n     <= 1'b1;
        fc       <= 3'b101;
        vpa_exp  <= 1'b0;
        iack_exp <= 1'b0;
    endtask

    task automatic check_ipl(logic [1:0] e);
        @(posedge clk32);
        ipl_chk <= 1'b1;
        ipl_exp <= e;
        @(posedge clk32);
        ipl_chk <= 1'b0;
    endtask

    // Write both registers, then load the expected timing of the mode
    task automatic select_mode(video_mode_e m);
        logic [15:0] sync_d;
        logic [15:0] res_d;
        int          idx;
        sync_d = (m == MODE_PAL) ? 16'h0200 : 16'h0000;
        res_d  = (m == MODE_MONO) ? 16'h0200 : 16'h0000;
        idx    = int'(m);
        bus_cycle({IO_PAGE, SYNC_REG_OFS}, sync_d, 1'b1, 1'b1, '1);
        bus_cycle({IO_PAGE, MODE_REG_OFS}, res_d, 1'b1, 1'b1, '1);
        exp_hper    = H_TOTAL[idx] * TICK_DIV;
        exp_hlow    = HSYNC_LEN[idx] * TICK_DIV;
        exp_vper    = V_TOTAL[idx] * exp_hper;
        exp_vlow    = VSYNC_LEN[idx] * exp_hper;
        exp_deline  = HDE_LEN[idx] * TICK_DIV;
        exp_delines = VDE_LEN[idx];
        exp_mono    = (m == MODE_MONO);
        if (m == MODE_MONO) begin
            exp_blank = 0;
        end else begin
            exp_blank = TICK_DIV * (VBLANK_LEN * H_TOTAL[idx]
                        + (V_TOTAL[idx] - VBLANK_LEN) * HBLANK_LEN);
        end
    endtask

    task automatic interrupt_checks;
        check_ipl(2'b01);               // Vertical pending masks level 2
        ack_cycle(LVL_VINT);
        check_ipl(2'b10);
        ack_cycle(LVL_HINT);
        check_ipl(2'b11);
        @(negedge hsync_n_o);
        check_ipl(2'b10);
        ack_cycle(LVL_HINT);
        check_ipl(2'b11);
        ack_cycle(LVL_MFP);
        @(posedge clk32);
        mfpint_n <= 1'b0;
        ipl_chk  <= 1'b1;
        ipl_exp  <= 2'b00;
        @(posedge clk32);
        mfpint_n <= 1'b1;
        ipl_chk  <= 1'b0;
        check_ipl(2'b11);
    endtask

    // ========================================================================
    // Stimulus
    // ========================================================================

    initial begin
        logic [22:0] a;
        logic [15:0] d;
        logic        use_sync;
        void'($urandom(39378));
        porb     = 1'b0;
        as_n     = 1'b1;
        rw       = 1'b1;
        uds_n    = 1'b1;
        mfpint_n = 1'b1;
        fc       = 3'b101;
        addr     = '0;
        din      = '0;
        repeat (2) @(posedge clk32);
        porb <= 1'b1;

        // Register write and readback
        repeat (12) begin
            d        = 16'($urandom);
            use_sync = 1'($urandom);
            a        = use_sync ? {IO_PAGE, SYNC_REG_OFS} : {IO_PAGE, MODE_REG_OFS};
            bus_cycle(a, d, 1'b1, 1'b1, '1);
            bus_cycle(a, 16'h0, 1'b0, 1'b1,
                      16'hFCFF | {6'h0, (use_sync ? {d[9], 1'b0} : d[9:8]), 8'h0});
        end

        // Unmapped addresses
        repeat (12) begin
            a = 23'($urandom);
            if (a == {IO_PAGE, SYNC_REG_OFS} || a == {IO_PAGE, MODE_REG_OFS}) begin
                a = a + 23'd1;
            end
            bus_cycle(a, 16'($urandom), 1'($urandom), 1'b0, '1);
        end

        // Timing per mode measured over one whole frame after the switch
        for (int m = 0; m < 3; m++) begin
            select_mode(video_mode_e'(m));
            @(negedge vsync_n_o);
            if (m == 0) begin
                ack_cycle(LVL_VINT);    // Both latches empty before the next vsync
                ack_cycle(LVL_HINT);
                check_ipl(2'b11);
            end
            @(negedge vsync_n_o);
            @(posedge clk32);
            meas <= 1'b1;
            if (m == 0) begin
                interrupt_checks();
            end
            @(negedge vsync_n_o);
            @(posedge clk32);
            meas <= 1'b0;
        end

        repeat (4) @(posedge clk32);
        $display("Regression passed");
        $finish;
    end

    initial begin
        #(WD_CYCLES * 100);
        $display("Watchdog timeout, the test sequence did not finish in time");
        $display("Regression failed");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
source/mcu_bus_pkg.sv
source/mcu_video_pkg.sv
source/cpu_port.sv
source/video_timing.sv
source/video_outputs.sv
source/gst_video_mcu.sv
dv/tb_gst_video_mcu.sv

// ==== run.sh ====
#!/bin/bash
# Build and run the testbench with Verilator; the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f vlog.f --top-module tb_gst_video_mcu \
    && ./obj_dir/Vtb_gst_video_mcu > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Regression failed" sim.log && exit 1
grep -q "Regression passed" sim.log || exit 1
exit 0
